// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := simd_issue_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
PASS_MSG  := All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass line shows up in the simulator output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/simd_issue_props.sv
// Issue handshake properties
`timescale 1ns/1ps

module simd_issue_props (
    input logic               clk_i,
    input logic               rstn_i,
    input logic               flush_i,
    input logic               req_i,
    input logic               ack_i,
    input simd_pkg::simd_wb_t wb_i
);

    int unsigned fail_cnt = 0;   // Failed assertions so far

    // An acknowledge answers a request that was up
    ack_needs_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $rose(ack_i) |-> $past(req_i))
        else begin
            $error("ack_o rose while req_i was low");
            fail_cnt++;
        end

    ack_held: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (ack_i && req_i) |=> ack_i)
        else begin
            $error("ack_o fell before req_i was released");
            fail_cnt++;
        end

    // Nothing from before a flush may leave
    flush_quiet: assert property (@(posedge clk_i) disable iff (!rstn_i)
        flush_i |=> !wb_i.valid)
        else begin
            $error("wb_o.valid high in the cycle after a flush");
            fail_cnt++;
        end

endmodule

bind simd_issue_top simd_issue_props u_props (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .flush_i (flush_i),
    .req_i   (req_i),
    .ack_i   (ack_o),
    .wb_i    (wb_o)
);

// File: bench/simd_issue_tb.sv
// SIMD issue scoreboard testbench
`timescale 1ns/1ps

module simd_issue_tb;

    localparam int DIV_LAT   = 32;
    localparam int VMAX_ELEM = 16;
    localparam int RING      = 64;   // Longer than any latency
    localparam int NUM_INSTR = 400;
    localparam int WAIT_MAX  = 200;

    logic                  clk_i;
    logic                  rstn_i;
    logic                  flush_i;
    logic                  req_i;
    simd_pkg::simd_instr_t instr_i;
    logic                  ack_o;
    logic                  cfg_we_i;
    logic [1:0]            cfg_addr_i;
    logic [7:0]            cfg_wdata_i;
    logic [7:0]            cfg_rdata_o;
    simd_pkg::simd_wb_t    wb_o;
    logic                  busy_o;

    integer                seed;
    int                    cycle;
    int                    outstanding;       // Writebacks still to come
    logic                  ack_seen;
    logic                  pending;           // Offered, not yet issued
    simd_pkg::simd_instr_t cur_instr;
    simd_pkg::simd_wb_t    exp_ring [RING];   // Expected writeback per cycle
    simd_pkg::sew_t        m_sew;
    simd_pkg::vl_t         m_vl;
    logic                  m_reuse;
    logic                  div_valid;
    simd_pkg::simd_instr_t div_last;          // Last long divide seen issuing
    logic                  div_inflight;
    int                    div_slot;
    simd_pkg::tag_t        next_tag;

    simd_issue_top #(
        .VMAX_ELEM (VMAX_ELEM),
        .DIV_LAT   (DIV_LAT)
    ) u_simd_issue_top (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .flush_i     (flush_i),
        .req_i       (req_i),
        .instr_i     (instr_i),
        .ack_o       (ack_o),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .wb_o        (wb_o),
        .busy_o      (busy_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "Stopped at cycle %0d", cycle);
    endtask

    task automatic check_wb(input simd_pkg::simd_wb_t got, input simd_pkg::simd_wb_t want);
        if ((got.valid !== want.valid) || (want.valid && (got.tag !== want.tag))) begin
            stop_run($sformatf("** Error: wb_o got %h expected %h at cycle %0d",
                               got, want, cycle));
        end
    endtask

    task automatic check_cfg(input logic [7:0] got, input logic [7:0] want,
                             input logic [1:0] addr);
        if (got !== want) begin
            stop_run($sformatf("** Error: cfg_rdata_o at address %h got %h expected %h",
                               addr, got, want));
        end
    endtask

    task automatic check_ack(input logic got, input logic want);
        if (got !== want) begin
            stop_run($sformatf("** Error: ack_o got %h expected %h at cycle %0d",
                               got, want, cycle));
        end
    endtask

    task automatic check_busy(input logic got, input logic want);
        if (got !== want) begin
            stop_run($sformatf("** Error: busy_o got %h expected %h at cycle %0d",
                               got, want, cycle));
        end
    endtask

    function automatic logic [7:0] model_rdata(input logic [1:0] addr);
        case (addr)
            simd_pkg::CFG_ADDR_SEW:   return {6'd0, m_sew};
            simd_pkg::CFG_ADDR_VL:    return {3'd0, m_vl};
            simd_pkg::CFG_ADDR_REUSE: return {7'd0, m_reuse};
            default:                  return 8'd0;
        endcase
    endfunction

    function automatic logic is_div(input simd_pkg::simd_instr_t ins);
        return (ins.op_class == simd_pkg::OP_DIV) || (ins.op_class == simd_pkg::OP_REM);
    endfunction

    // Same operands as the last long divide, so its result is already known
    function automatic logic reuse_match(input simd_pkg::simd_instr_t ins);
        logic same_src;
        same_src = ins.is_opvx ? (ins.rs1 == div_last.rs1) : (ins.vs1 == div_last.vs1);
        return m_reuse && div_valid && is_div(ins) && same_src &&
               (ins.is_opvx == div_last.is_opvx) && (ins.vs2 == div_last.vs2);
    endfunction

    function automatic int expect_lat(input simd_pkg::simd_instr_t ins);
        int depth;
        depth = 0;
        while ((1 << depth) < int'(m_vl)) begin
            depth++;
        end
        case (ins.op_class)
            simd_pkg::OP_ALU: return 1;
            simd_pkg::OP_MUL: return (m_sew == simd_pkg::SEW_64) ? 3 : 2;
            simd_pkg::OP_MAC: return (m_sew == simd_pkg::SEW_64) ? 4 : 3;
            simd_pkg::OP_RED: return depth + 2;
            simd_pkg::OP_DIV, simd_pkg::OP_REM: return reuse_match(ins) ? 1 : DIV_LAT;
            default: return 0;   // No writeback
        endcase
    endfunction

    // Offer in this cycle held back by a taken slot or a busy divider
    function automatic logic would_stall(input simd_pkg::simd_instr_t ins);
        int lat;
        lat = expect_lat(ins);
        if ((lat > 0) && exp_ring[(cycle + lat) % RING].valid) begin
            return 1'b1;
        end
        return is_div(ins) && !reuse_match(ins) && div_inflight && (cycle < div_slot);
    endfunction

    task automatic clear_model();
        for (int i = 0; i < RING; i++) begin
            exp_ring[i] = '0;
        end
        outstanding  = 0;
        div_inflight = 1'b0;
    endtask

    // Issue edge is the current cycle
    task automatic schedule(input simd_pkg::simd_instr_t ins);
        int   lat;
        int   slot;
        logic long_div;
        long_div = is_div(ins) && !reuse_match(ins);
        lat      = expect_lat(ins);
        pending  = 1'b0;
        if (long_div) begin
            if (div_inflight && (cycle <= div_slot)) begin
                stop_run("A second long divide issued while the divider was still busy");
            end
            div_inflight = 1'b1;
            div_slot     = cycle + lat - 1;
            div_valid    = 1'b1;
            div_last     = ins;
        end
        if (lat > 0) begin
            slot = cycle + lat - 1;
            if (exp_ring[slot % RING].valid) begin
                stop_run("Two writebacks were issued for the same cycle");
            end
            exp_ring[slot % RING].valid = 1'b1;
            exp_ring[slot % RING].tag   = ins.tag;
            outstanding++;
        end
    endtask

    // One clock, then the model looks at the new cycle
    task automatic tick();
        logic               flushed;
        simd_pkg::simd_wb_t want;
        flushed = flush_i;
        @(posedge clk_i);
        #1;
        cycle++;
        if (u_simd_issue_top.u_props.fail_cnt != 0) begin
            stop_run("A handshake or writeback assertion failed");
        end
        if (flushed) begin
            clear_model();
        end
        if (ack_o && !ack_seen && pending) begin
            schedule(cur_instr);
        end
        ack_seen = ack_o;
        check_busy(busy_o, outstanding != 0);   // Anything still due to write back
        want = exp_ring[cycle % RING];
        check_wb(wb_o, want);
        if (want.valid) begin
            outstanding--;
        end
        exp_ring[cycle % RING] = '0;
    endtask

    task automatic write_cfg(input logic [1:0] addr, input logic [7:0] data);
        cfg_we_i    = 1'b1;
        cfg_addr_i  = addr;
        cfg_wdata_i = data;
        case (addr)
            simd_pkg::CFG_ADDR_SEW:   m_sew = data[1:0];
            simd_pkg::CFG_ADDR_REUSE: m_reuse = data[0];
            simd_pkg::CFG_ADDR_VL: begin
                if (data == 8'd0) begin
                    m_vl = 5'd1;
                end else if (data > 8'(VMAX_ELEM)) begin
                    m_vl = 5'(VMAX_ELEM);
                end else begin
                    m_vl = data[4:0];
                end
            end
            default: ;
        endcase
        tick();
        cfg_we_i = 1'b0;
        check_cfg(cfg_rdata_o, model_rdata(addr), addr);
    endtask

    task automatic make_instr(output simd_pkg::simd_instr_t ins);
        logic [31:0] r;
        r           = $random(seed);
        ins.is_opvx = r[4];
        ins.vs1     = $random(seed);
        ins.vs2     = $random(seed);
        ins.rs1     = $random(seed);
        ins.tag     = next_tag;
        next_tag++;
        if (r[3:0] < 4'd3) begin
            ins.op_class = simd_pkg::OP_ALU;
        end else if (r[3:0] < 4'd5) begin
            ins.op_class = simd_pkg::OP_MUL;
        end else if (r[3:0] < 4'd7) begin
            ins.op_class = simd_pkg::OP_MAC;
        end else if (r[3:0] < 4'd9) begin
            ins.op_class = simd_pkg::OP_RED;
        end else if (r[3:0] < 4'd15) begin
            ins.op_class = r[5] ? simd_pkg::OP_DIV : simd_pkg::OP_REM;
            if (div_valid && (r[3:0] < 4'd13)) begin   // Mostly repeat the operands
                ins.is_opvx = div_last.is_opvx;
                ins.vs1     = div_last.vs1;
                ins.vs2     = div_last.vs2;
                ins.rs1     = div_last.rs1;
            end
        end else begin
            ins.op_class = simd_pkg::OP_NONE;
        end
    endtask

    task automatic issue_one(input simd_pkg::simd_instr_t ins);
        logic want_ack;
        int   waited;
        cur_instr = ins;
        pending   = 1'b1;
        req_i     = 1'b1;
        instr_i   = ins;
        tick();
        check_ack(ack_o, 1'b0);
        want_ack = 1'b0;
        waited   = 0;
        while (!want_ack) begin   // Offer held while a conflict lasts
            if (waited >= WAIT_MAX) begin
                stop_run("Timed out waiting for ack_o to rise");
            end
            want_ack = !would_stall(ins);
            tick();
            check_ack(ack_o, want_ack);
            waited++;
        end
        req_i = 1'b0;
        tick();
        check_ack(ack_o, 1'b0);
    endtask

    initial begin
        logic [31:0]           r;
        simd_pkg::simd_instr_t ins;
        int                    waited;
        seed        = 32'h89ec;
        rstn_i      = 1'b0;
        flush_i     = 1'b0;
        req_i       = 1'b0;
        instr_i     = '0;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = 2'd0;
        cfg_wdata_i = 8'd0;
        cycle       = 0;
        ack_seen    = 1'b0;
        pending     = 1'b0;
        next_tag    = '0;
        m_sew       = simd_pkg::SEW_8;
        m_vl        = 5'd1;
        m_reuse     = 1'b1;
        div_valid   = 1'b0;
        div_slot    = 0;
        clear_model();
        repeat (8) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        check_ack(ack_o, 1'b0);
        check_wb(wb_o, '0);
        check_busy(busy_o, 1'b0);
        for (int a = 0; a < 3; a++) begin
            cfg_addr_i = 2'(a);
            tick();
            check_cfg(cfg_rdata_o, model_rdata(cfg_addr_i), cfg_addr_i);
        end
        // VL clamp corners
        write_cfg(simd_pkg::CFG_ADDR_VL, 8'd0);
        write_cfg(simd_pkg::CFG_ADDR_VL, 8'd200);
        write_cfg(simd_pkg::CFG_ADDR_VL, 8'd17);
        write_cfg(simd_pkg::CFG_ADDR_VL, 8'd16);
        for (int n = 0; n < NUM_INSTR; n++) begin
            r = $random(seed);
            if (r[2:0] == 3'd0) begin
                write_cfg(r[9:8], r[12] ? r[23:16] : {3'd0, r[20:16]});
            end
            if (r[5:3] == 3'd0) begin
                flush_i = 1'b1;
                tick();
                flush_i = 1'b0;
            end
            repeat (r[11:10]) tick();
            make_instr(ins);
            issue_one(ins);
        end
        waited = 0;
        while (busy_o) begin
            if (waited >= WAIT_MAX) begin
                stop_run("Timed out waiting for busy_o to fall");
            end
            tick();
            waited++;
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// File: build.f
hw/simd_pkg.sv
hw/simd_cfg_regs.sv
hw/simd_issue_ctrl.sv
hw/simd_score_board.sv
hw/simd_issue_top.sv
bench/simd_issue_props.sv
bench/simd_issue_tb.sv

// File: hw/simd_cfg_regs.sv
// SIMD configuration registers
`timescale 1ns/1ps

module simd_cfg_regs #(
    parameter int VMAX_ELEM = 16
) (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  logic           cfg_we_i,
    input  logic [1:0]     cfg_addr_i,
    input  logic [7:0]     cfg_wdata_i,
    output logic [7:0]     cfg_rdata_o,  // Combinational read-back
    output simd_pkg::sew_t sew_o,
    output simd_pkg::vl_t  vl_o,
    output logic           reuse_en_o
);

    simd_pkg::sew_t sew_q;
    simd_pkg::vl_t  vl_q;
    simd_pkg::vl_t  vl_clamp;
    logic           reuse_q;

    // Keep VL inside 1 to VMAX_ELEM
    always_comb begin
        if (cfg_wdata_i == 8'd0) begin
            vl_clamp = simd_pkg::VL_MIN;
        end else if (cfg_wdata_i > VMAX_ELEM) begin
            vl_clamp = simd_pkg::vl_t'(VMAX_ELEM);
        end else begin
            vl_clamp = cfg_wdata_i[4:0];
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            sew_q   <= simd_pkg::SEW_8;
            vl_q    <= simd_pkg::VL_MIN;
            reuse_q <= 1'b1;  // Divide reuse on after reset
        end else if (cfg_we_i) begin
            case (cfg_addr_i)
                simd_pkg::CFG_ADDR_SEW:   sew_q   <= cfg_wdata_i[1:0];
                simd_pkg::CFG_ADDR_VL:    vl_q    <= vl_clamp;
                simd_pkg::CFG_ADDR_REUSE: reuse_q <= cfg_wdata_i[0];
                default: ;                                            // Unmapped
            endcase
        end
    end

    always_comb begin
        case (cfg_addr_i)
            simd_pkg::CFG_ADDR_SEW:   cfg_rdata_o = {6'd0, sew_q};
            simd_pkg::CFG_ADDR_VL:    cfg_rdata_o = {3'd0, vl_q};
            simd_pkg::CFG_ADDR_REUSE: cfg_rdata_o = {7'd0, reuse_q};
            default:                  cfg_rdata_o = 8'd0;
        endcase
    end

    assign sew_o      = sew_q;
    assign vl_o       = vl_q;
    assign reuse_en_o = reuse_q;

endmodule

// File: hw/simd_issue_ctrl.sv
// Four-phase issue front end
`timescale 1ns/1ps

module simd_issue_ctrl (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  flush_i,
    // Issuer side
    input  logic                  req_i,
    input  simd_pkg::simd_instr_t instr_i,
    output logic                  ack_o,
    // Scoreboard side
    output logic                  valid_o,    // Instruction on offer
    output simd_pkg::simd_instr_t instr_o,
    input  logic                  issued_i    // Taken at this edge
);

    typedef enum logic [1:0] {
        IDLE,
        OFFER,
        ACK
    } state_e;

    state_e                state_q;
    state_e                state_d;
    simd_pkg::simd_instr_t instr_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_i) begin
                    state_d = OFFER;
                end
            end
            OFFER: begin
                // A flush drops the offer but still finishes the handshake
                if (issued_i || flush_i) begin
                    state_d = ACK;
                end
            end
            ACK: begin
                if (!req_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Hold the instruction stable while the scoreboard stalls
    always_ff @(posedge clk_i) begin
        if ((state_q == IDLE) && req_i) begin
            instr_q <= instr_i;
        end
    end

    assign valid_o = (state_q == OFFER);
    assign ack_o   = (state_q == ACK);   // Registered through the state
    assign instr_o = instr_q;

endmodule

// File: hw/simd_issue_top.sv
// SIMD issue subsystem top
`timescale 1ns/1ps

module simd_issue_top #(
    parameter int VMAX_ELEM = 16,
    parameter int DIV_LAT   = 32
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  flush_i,
    // Four-phase issue port
    input  logic                  req_i,
    input  simd_pkg::simd_instr_t instr_i,
    output logic                  ack_o,
    // Configuration port
    input  logic                  cfg_we_i,
    input  logic [1:0]            cfg_addr_i,
    input  logic [7:0]            cfg_wdata_i,
    output logic [7:0]            cfg_rdata_o,
    // Writeback and status
    output simd_pkg::simd_wb_t    wb_o,
    output logic                  busy_o
);

    simd_pkg::sew_t        sew;
    simd_pkg::vl_t         vl;
    logic                  reuse_en;
    logic                  offer_valid;
    logic                  issued;
    simd_pkg::simd_instr_t offer_instr;

    simd_cfg_regs #(
        .VMAX_ELEM (VMAX_ELEM)
    ) u_cfg_regs (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .sew_o       (sew),
        .vl_o        (vl),
        .reuse_en_o  (reuse_en)
    );

    simd_issue_ctrl u_issue_ctrl (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .flush_i  (flush_i),
        .req_i    (req_i),
        .instr_i  (instr_i),
        .ack_o    (ack_o),
        .valid_o  (offer_valid),
        .instr_o  (offer_instr),
        .issued_i (issued)
    );

    simd_score_board #(
        .VMAX_ELEM (VMAX_ELEM),
        .DIV_LAT   (DIV_LAT)
    ) u_score_board (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .flush_i    (flush_i),
        .valid_i    (offer_valid),
        .instr_i    (offer_instr),
        .sew_i      (sew),
        .vl_i       (vl),
        .reuse_en_i (reuse_en),
        .issued_o   (issued),
        .wb_o       (wb_o),
        .busy_o     (busy_o)
    );

endmodule

// File: hw/simd_pkg.sv
// SIMD issue scoreboard definitions
package simd_pkg;

    // Widths with a meaning of their own
    typedef logic [31:0] data_t;      // Operand value
    typedef logic [5:0]  tag_t;       // Identifier returned at writeback
    typedef logic [2:0]  op_class_t;  // Operation class
    typedef logic [1:0]  sew_t;       // Element width code
    typedef logic [4:0]  vl_t;        // Vector length in elements
    typedef logic [5:0]  lat_t;       // Latency in cycles

    // Operation classes
    localparam op_class_t OP_ALU  = 3'd0;
    localparam op_class_t OP_MUL  = 3'd1;
    localparam op_class_t OP_MAC  = 3'd2;
    localparam op_class_t OP_RED  = 3'd3;
    localparam op_class_t OP_DIV  = 3'd4;
    localparam op_class_t OP_REM  = 3'd5;
    localparam op_class_t OP_NONE = 3'd7;  // Accepted but never written back

    // Element width codes
    localparam sew_t SEW_8  = 2'd0;
    localparam sew_t SEW_16 = 2'd1;
    localparam sew_t SEW_32 = 2'd2;
    localparam sew_t SEW_64 = 2'd3;

    localparam vl_t VL_MIN = 5'd1;  // Shortest legal vector

    // Fixed latencies per class
    localparam lat_t LAT_ALU      = 6'd1;
    localparam lat_t LAT_MUL      = 6'd2;
    localparam lat_t LAT_MUL64    = 6'd3;
    localparam lat_t LAT_MAC      = 6'd3;
    localparam lat_t LAT_MAC64    = 6'd4;
    localparam lat_t LAT_RED_BASE = 6'd2;  // Added to clog2 of VL
    localparam lat_t LAT_REUSE    = 6'd1;  // Divide with a known result

    // Configuration register map
    localparam logic [1:0] CFG_ADDR_SEW   = 2'd0;
    localparam logic [1:0] CFG_ADDR_VL    = 2'd1;
    localparam logic [1:0] CFG_ADDR_REUSE = 2'd2;

    // Instruction as seen by the scoreboard
    typedef struct packed {
        op_class_t op_class;
        logic      is_opvx;   // rs1 replaces vs1
        data_t     vs1;
        data_t     vs2;
        data_t     rs1;
        tag_t      tag;
    } simd_instr_t;

    // Shared writeback port
    typedef struct packed {
        logic valid;
        tag_t tag;
    } simd_wb_t;

endpackage

// File: hw/simd_score_board.sv
// Vector issue latency scoreboard
`timescale 1ns/1ps

module simd_score_board #(
    parameter int VMAX_ELEM = 16,
    parameter int DIV_LAT   = 32
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  flush_i,
    input  logic                  valid_i,     // Instruction on offer
    input  simd_pkg::simd_instr_t instr_i,
    input  simd_pkg::sew_t        sew_i,
    input  simd_pkg::vl_t         vl_i,
    input  logic                  reuse_en_i,
    output logic                  issued_o,    // Enters the pipes at this edge
    output simd_pkg::simd_wb_t    wb_o,
    output logic                  busy_o
);

    // Longest non-divide latency decides how many lanes exist
    localparam int RED_MAX   = $clog2(VMAX_ELEM) + int'(simd_pkg::LAT_RED_BASE);
    localparam int MAX_LAT   = (RED_MAX > int'(simd_pkg::LAT_MAC64)) ?
                               RED_MAX : int'(simd_pkg::LAT_MAC64);
    localparam int NUM_LANES = MAX_LAT;  // Latencies 2 to MAX_LAT and the divider

    simd_pkg::lat_t      lat;
    logic                is_div;
    logic                pair_ok;
    logic                opnd_ok;
    logic                reuse_hit;
    logic                long_div;
    logic                wb_req;
    logic                div_busy;
    logic                stall;
    logic                accept;
    logic                load_wb;
    logic [NUM_LANES-1:0] lane_claim;
    logic [NUM_LANES-1:0] lane_busy;
    simd_pkg::simd_wb_t  lane_end [NUM_LANES];
    simd_pkg::simd_wb_t  wb_d;
    simd_pkg::simd_wb_t  wb_q;

    // Last long divide, kept for result reuse
    simd_pkg::op_class_t prev_op_q;
    logic                prev_opvx_q;
    simd_pkg::data_t     prev_vs1_q;
    simd_pkg::data_t     prev_vs2_q;
    simd_pkg::data_t     prev_rs1_q;

    // Reduction tree depth
    function automatic simd_pkg::lat_t clog2_vl(input simd_pkg::vl_t vl);
        simd_pkg::lat_t res;
        res = '0;
        for (int i = 0; i < $bits(simd_pkg::vl_t); i++) begin
            if (vl > (simd_pkg::vl_t'(1) << i)) begin
                res = simd_pkg::lat_t'(i + 1);
            end
        end
        return res;
    endfunction

    assign is_div  = (instr_i.op_class == simd_pkg::OP_DIV) ||
                     (instr_i.op_class == simd_pkg::OP_REM);
    // DIV and REM share a result, so any divide-class pair matches
    assign pair_ok = (prev_op_q == simd_pkg::OP_DIV) || (prev_op_q == simd_pkg::OP_REM);
    assign opnd_ok = (prev_opvx_q == instr_i.is_opvx) && (prev_vs2_q == instr_i.vs2) &&
                     (instr_i.is_opvx ? (prev_rs1_q == instr_i.rs1) :
                                        (prev_vs1_q == instr_i.vs1));

    assign reuse_hit = reuse_en_i && is_div && pair_ok && opnd_ok;
    assign long_div  = is_div && !reuse_hit;
    assign wb_req    = (instr_i.op_class != simd_pkg::OP_NONE);

    always_comb begin
        case (instr_i.op_class)
            simd_pkg::OP_MUL: begin
                lat = (sew_i == simd_pkg::SEW_64) ? simd_pkg::LAT_MUL64 : simd_pkg::LAT_MUL;
            end
            simd_pkg::OP_MAC: begin
                lat = (sew_i == simd_pkg::SEW_64) ? simd_pkg::LAT_MAC64 : simd_pkg::LAT_MAC;
            end
            simd_pkg::OP_RED: lat = clog2_vl(vl_i) + simd_pkg::LAT_RED_BASE;
            simd_pkg::OP_DIV,
            simd_pkg::OP_REM: begin
                lat = reuse_hit ? simd_pkg::LAT_REUSE : simd_pkg::lat_t'(DIV_LAT);
            end
            default: lat = simd_pkg::LAT_ALU;
        endcase
    end

    // Completion slot taken, or a second long divide on a busy divider
    assign div_busy = lane_busy[NUM_LANES-1];
    assign stall    = (wb_req && (|lane_claim)) || (long_div && div_busy);
    assign accept   = valid_i && !stall && !flush_i;
    assign load_wb  = accept && wb_req;
    assign issued_o = accept;

    // One shift pipe per latency, the last lane being the divider
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        localparam int LANE_LAT = (k == NUM_LANES - 1) ? DIV_LAT : k + 2;
        localparam int DEPTH    = LANE_LAT - 1;

        simd_pkg::simd_wb_t stage_q [DEPTH];
        logic               claim;
        logic               busy;

        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                for (int j = 0; j < DEPTH; j++) begin
                    stage_q[j] <= '0;
                end
            end else if (flush_i) begin
                for (int j = 0; j < DEPTH; j++) begin
                    stage_q[j] <= '0;
                end
            end else begin
                stage_q[0].valid <= load_wb && (lat == simd_pkg::lat_t'(LANE_LAT));
                stage_q[0].tag   <= instr_i.tag;
                for (int j = 1; j < DEPTH; j++) begin
                    stage_q[j] <= stage_q[j-1];
                end
            end
        end

        // Stage j reaches writeback LANE_LAT-1-j edges from now
        always_comb begin
            claim = 1'b0;
            busy  = 1'b0;
            for (int j = 0; j < DEPTH; j++) begin
                if (stage_q[j].valid) begin
                    busy = 1'b1;
                    if (lat == simd_pkg::lat_t'(LANE_LAT - 1 - j)) begin
                        claim = 1'b1;
                    end
                end
            end
        end

        assign lane_claim[k] = claim;
        assign lane_busy[k]  = busy;
        assign lane_end[k]   = stage_q[DEPTH-1];
    end

    // At most one source is valid thanks to the stall
    always_comb begin
        wb_d = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            if (lane_end[k].valid) begin
                wb_d = lane_end[k];
            end
        end
        if (load_wb && (lat == simd_pkg::lat_t'(1))) begin
            wb_d.valid = 1'b1;              // One-cycle slot
            wb_d.tag   = instr_i.tag;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wb_q <= '0;
        end else if (flush_i) begin
            wb_q <= '0;
        end else begin
            wb_q <= wb_d;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            prev_op_q <= simd_pkg::OP_NONE;  // Nothing to reuse yet
        end else if (accept && long_div) begin
            prev_op_q <= instr_i.op_class;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept && long_div) begin
            prev_opvx_q <= instr_i.is_opvx;
            prev_vs1_q  <= instr_i.vs1;
            prev_vs2_q  <= instr_i.vs2;
            prev_rs1_q  <= instr_i.rs1;
        end
    end

    assign wb_o   = wb_q;
    assign busy_o = (|lane_busy) || wb_q.valid;

endmodule
